// File: sources.f
src/pmu_pkg.sv
src/csr_req_if.sv
src/csr_issue.sv
src/pmu.sv
src/pmu_top.sv
testbench/pmu_asserts.sv
testbench/pmu_tb.sv

// File: src/csr_issue.sv
`timescale 1ns/1ps

module csr_issue (
    input  logic                     clk_free,
    input  logic                     rstn,
    input  logic                     csr_valid,
    input  pmu_pkg::csr_op_e         csr_op,
    input  logic [11:0]              csr_addr,
    input  logic [pmu_pkg::xlen-1:0] csr_src,
    csr_req_if.issue                 req,
    output logic                     rd_valid,
    output logic [pmu_pkg::xlen-1:0] rd_data,
    output logic                     rd_ill
);

    logic                     src_nz;
    logic                     wr_op;
    logic [pmu_pkg::xlen-1:0] wdata;

    assign src_nz = |csr_src;

    // set or clear with a zero mask is a pure read.
    always_comb begin
        wdata = req.rdata;
        wr_op = 1'b0;
        case (csr_op)
            pmu_pkg::csr_rw: begin
                wdata = csr_src;
                wr_op = 1'b1;
            end
            pmu_pkg::csr_rs: begin
                wdata = req.rdata | csr_src;
                wr_op = src_nz;
            end
            pmu_pkg::csr_rc: begin
                wdata = req.rdata & ~csr_src;
                wr_op = src_nz;
            end
            default: begin
                wdata = req.rdata; // idle code, read only.
                wr_op = 1'b0;
            end
        endcase
    end

    assign req.rd_chk = csr_valid;
    assign req.wr_chk = csr_valid && wr_op;
    assign req.raddr  = csr_addr;
    assign req.wdata  = wdata;

    // illegal accesses never reach the registers.
    assign req.wr = req.wr_chk && !req.ill;

    always_ff @(posedge clk_free or negedge rstn) begin
        if (!rstn) begin
            rd_valid <= 1'b0;
            rd_ill   <= 1'b0;
        end else begin
            rd_valid <= csr_valid;
            rd_ill   <= csr_valid && req.ill;
        end
    end

    // old value, qualified by rd_valid.
    always_ff @(posedge clk_free) begin
        if (csr_valid) begin
            rd_data <= req.rdata;
        end
    end

endmodule

// File: src/csr_req_if.sv
`timescale 1ns/1ps

interface csr_req_if;

    logic                     rd_chk; // exe-stage read check.
    logic                     wr_chk; // exe-stage write check.
    logic [11:0]              raddr;  // also the write address.
    logic                     wr;
    logic [pmu_pkg::xlen-1:0] wdata;
    logic [pmu_pkg::xlen-1:0] rdata;  // old value, same cycle.
    logic                     ill;

    modport issue (
        output rd_chk,
        output wr_chk,
        output raddr,
        output wr,
        output wdata,
        input  rdata,
        input  ill
    );

    modport counters (
        input  rd_chk,
        input  wr_chk,
        input  raddr,
        input  wr,
        input  wdata,
        output rdata,
        output ill
    );

endinterface

// File: src/pmu.sv
`timescale 1ns/1ps

module pmu (
    input  logic                     clk_free,
    input  logic                     rstn,
    input  logic [pmu_pkg::xlen-1:0] cpu_id,
    input  logic                     inst_valid,
    input  pmu_pkg::prv_e            prv,
    input  logic [63:0]              mtime,
    output logic [63:0]              mcycle,
    csr_req_if.counters              req
);

    logic [pmu_pkg::xlen-1:0] scounteren;
    logic [pmu_pkg::xlen-1:0] mcounteren;
    logic [pmu_pkg::xlen-1:0] mhartid;
    logic [63:0]              minstret;

    logic       acc;
    logic       ucnt;
    logic [4:0] cidx;
    logic       ro_wr;
    logic       prv_low;

    assign acc     = req.rd_chk || req.wr_chk;
    assign ucnt    = req.raddr[11:5] == pmu_pkg::csr_ucnt_prefix;
    assign cidx    = req.raddr[4:0]; // counter index into the enables.
    assign ro_wr   = req.wr_chk && req.raddr[11:10] == pmu_pkg::csr_ro_field;
    assign prv_low = req.raddr[9:8] > prv;

    // user counters need the enable bit at every level below the owner.
    assign req.ill = acc && (ro_wr || prv_low ||
                     (ucnt && prv < pmu_pkg::prv_m && !mcounteren[cidx]) ||
                     (ucnt && prv < pmu_pkg::prv_s && !scounteren[cidx]));

    logic wr_scen;
    logic wr_mcen;
    logic wr_cyc_l;
    logic wr_cyc_h;
    logic wr_ins_l;
    logic wr_ins_h;

    assign wr_scen  = req.wr && req.raddr == pmu_pkg::csr_scounteren_addr;
    assign wr_mcen  = req.wr && req.raddr == pmu_pkg::csr_mcounteren_addr;
    assign wr_cyc_l = req.wr && req.raddr == pmu_pkg::csr_mcycle_addr;
    assign wr_cyc_h = req.wr && req.raddr == pmu_pkg::csr_mcycleh_addr;
    assign wr_ins_l = req.wr && req.raddr == pmu_pkg::csr_minstret_addr;
    assign wr_ins_h = req.wr && req.raddr == pmu_pkg::csr_minstreth_addr;

    always_ff @(posedge clk_free or negedge rstn) begin
        if (!rstn) begin
            scounteren <= '0;
            mcounteren <= '0;
        end else begin
            if (wr_scen) begin
                scounteren <= req.wdata;
            end
            if (wr_mcen) begin
                mcounteren <= req.wdata;
            end
        end
    end

    // a write to either half stops the count for that cycle.
    always_ff @(posedge clk_free or negedge rstn) begin
        if (!rstn) begin
            mcycle <= 64'd0;
        end else if (wr_cyc_l) begin
            mcycle[31:0] <= req.wdata;
        end else if (wr_cyc_h) begin
            mcycle[63:32] <= req.wdata;
        end else begin
            mcycle <= mcycle + 64'd1;
        end
    end

    always_ff @(posedge clk_free or negedge rstn) begin
        if (!rstn) begin
            minstret <= 64'd0;
        end else if (wr_ins_l) begin
            minstret[31:0] <= req.wdata;
        end else if (wr_ins_h) begin
            minstret[63:32] <= req.wdata;
        end else begin
            minstret <= minstret + {63'd0, inst_valid};
        end
    end

    always_ff @(posedge clk_free or negedge rstn) begin
        if (!rstn) begin
            mhartid <= '0;
        end else begin
            mhartid <= cpu_id; // sampled, one cycle late.
        end
    end

    // unimplemented addresses read zero.
    always_comb begin
        req.rdata = '0;
        case (req.raddr)
            pmu_pkg::csr_cycle_addr:      req.rdata = mcycle[31:0];
            pmu_pkg::csr_cycle_h_addr:    req.rdata = mcycle[63:32];
            pmu_pkg::csr_time_addr:       req.rdata = mtime[31:0];
            pmu_pkg::csr_time_h_addr:     req.rdata = mtime[63:32];
            pmu_pkg::csr_instret_addr:    req.rdata = minstret[31:0];
            pmu_pkg::csr_instret_h_addr:  req.rdata = minstret[63:32];
            pmu_pkg::csr_scounteren_addr: req.rdata = scounteren;
            pmu_pkg::csr_mcounteren_addr: req.rdata = mcounteren;
            pmu_pkg::csr_mcycle_addr:     req.rdata = mcycle[31:0];
            pmu_pkg::csr_mcycleh_addr:    req.rdata = mcycle[63:32];
            pmu_pkg::csr_minstret_addr:   req.rdata = minstret[31:0];
            pmu_pkg::csr_minstreth_addr:  req.rdata = minstret[63:32];
            pmu_pkg::csr_mhartid_addr:    req.rdata = mhartid;
            default:                      req.rdata = '0;
        endcase
    end

endmodule

// File: src/pmu_pkg.sv
package pmu_pkg;

    // rv32 only.
    localparam int xlen = 32;

    // user-level counter aliases, read only.
    localparam logic [11:0] csr_cycle_addr     = 12'hc00;
    localparam logic [11:0] csr_time_addr      = 12'hc01;
    localparam logic [11:0] csr_instret_addr   = 12'hc02;
    localparam logic [11:0] csr_cycle_h_addr   = 12'hc80;
    localparam logic [11:0] csr_time_h_addr    = 12'hc81;
    localparam logic [11:0] csr_instret_h_addr = 12'hc82;

    // counter enables.
    localparam logic [11:0] csr_scounteren_addr = 12'h106; // supervisor rw.
    localparam logic [11:0] csr_mcounteren_addr = 12'h306; // machine rw.

    // machine counters.
    localparam logic [11:0] csr_mcycle_addr    = 12'hb00;
    localparam logic [11:0] csr_mcycleh_addr   = 12'hb80;
    localparam logic [11:0] csr_minstret_addr  = 12'hb02;
    localparam logic [11:0] csr_minstreth_addr = 12'hb82;

    // machine info, read only.
    localparam logic [11:0] csr_mhartid_addr = 12'hf14;

    // addr[11:5] of the user counter block 0xc00..0xc1f.
    localparam logic [6:0] csr_ucnt_prefix = 7'b1100_000;

    // addr[11:10] marking a read-only csr.
    localparam logic [1:0] csr_ro_field = 2'b11;

    // privilege levels, encoded as in the spec.
    // the hypervisor code 2 is not used here.
    typedef enum logic [1:0] {
        prv_u = 2'd0,
        prv_s = 2'd1,
        prv_m = 2'd3
    } prv_e;

    // csr opcodes.
    // low two bits of funct3, so 0 is free for idle.
    typedef enum logic [1:0] {
        csr_none = 2'd0,
        csr_rw   = 2'd1,
        csr_rs   = 2'd2,
        csr_rc   = 2'd3
    } csr_op_e;

endpackage

// File: src/pmu_top.sv
`timescale 1ns/1ps

module pmu_top (
    input  logic                     clk_free,
    input  logic                     rstn,
    input  logic [pmu_pkg::xlen-1:0] cpu_id,
    input  logic                     inst_valid,
    input  pmu_pkg::prv_e            prv,
    input  logic [63:0]              mtime,

    // csr command in.
    input  logic                     csr_valid,
    input  pmu_pkg::csr_op_e         csr_op,
    input  logic [11:0]              csr_addr,
    input  logic [pmu_pkg::xlen-1:0] csr_src,

    // result, one cycle after the command.
    output logic                     rd_valid,
    output logic [pmu_pkg::xlen-1:0] rd_data,
    output logic                     rd_ill,
    output logic [63:0]              mcycle
);

    csr_req_if req_if ();

    csr_issue csr_issue_inst (
        .clk_free  (clk_free),
        .rstn      (rstn),
        .csr_valid (csr_valid),
        .csr_op    (csr_op),
        .csr_addr  (csr_addr),
        .csr_src   (csr_src),
        .req       (req_if.issue),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_ill    (rd_ill)
    );

    pmu pmu_inst (
        .clk_free   (clk_free),
        .rstn       (rstn),
        .cpu_id     (cpu_id),
        .inst_valid (inst_valid),
        .prv        (prv),
        .mtime      (mtime),
        .mcycle     (mcycle),
        .req        (req_if.counters)
    );

endmodule

// File: testbench/pmu_asserts.sv
`timescale 1ns/1ps

module pmu_asserts (
    input logic clk_free,
    input logic rstn,
    input logic csr_valid,
    input logic rd_valid,
    input logic wr,
    input logic ill
);

    int fail_count = 0; // failed assertions so far.

    // one result per command, one cycle later.
    rd_follows_cmd: assert property (@(posedge clk_free) disable iff (!rstn)
        csr_valid |=> rd_valid)
        else begin
            $error("rd_valid missing one cycle after csr_valid");
            fail_count = fail_count + 1;
        end

    rd_needs_cmd: assert property (@(posedge clk_free) disable iff (!rstn)
        !csr_valid |=> !rd_valid)
        else begin
            $error("rd_valid raised without a command");
            fail_count = fail_count + 1;
        end

    rd_low_in_reset: assert property (@(posedge clk_free) !rstn |-> (rd_valid !== 1'b1))
        else begin
            $error("rd_valid high while in reset");
            fail_count = fail_count + 1;
        end

    no_wr_on_ill: assert property (@(posedge clk_free) disable iff (!rstn) !(wr && ill))
        else begin
            $error("csr write issued on an illegal access");
            fail_count = fail_count + 1;
        end

endmodule

bind pmu_top pmu_asserts pmu_asserts_inst (
    .clk_free  (clk_free),
    .rstn      (rstn),
    .csr_valid (csr_valid),
    .rd_valid  (rd_valid),
    .wr        (req_if.wr),
    .ill       (req_if.ill)
);

// File: testbench/pmu_tb.sv
`timescale 1ns/1ps

module pmu_tb;

    localparam int reset_cycles = 8;

    logic                     clk_free = 1'b0;
    logic                     rstn;
    logic [pmu_pkg::xlen-1:0] cpu_id;
    logic                     inst_valid;
    pmu_pkg::prv_e            prv;
    logic [63:0]              mtime;
    logic                     csr_valid;
    pmu_pkg::csr_op_e         csr_op;
    logic [11:0]              csr_addr;
    logic [pmu_pkg::xlen-1:0] csr_src;
    logic                     rd_valid;
    logic [pmu_pkg::xlen-1:0] rd_data;
    logic                     rd_ill;
    logic [63:0]              mcycle;

    logic [31:0] t_prv[$];
    logic [31:0] t_id[$];
    logic [31:0] t_op[$];
    logic [31:0] t_addr[$];
    logic [31:0] t_src[$];
    logic [31:0] t_ill[$];
    logic [31:0] t_rd[$];

    // reference counters and the write pending for the next edge.
    logic [63:0] m_cycle;
    logic [63:0] m_instret;
    logic        pend_wr;
    logic [11:0] pend_addr;
    logic [31:0] pend_wdata;
    int          cycles = 0;
    int          cycle_limit = 0;

    pmu_top pmu_top_inst (.*);

    always #20 clk_free = ~clk_free;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else stop_on_error($sformatf("Fail %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_result(input logic exp_ill, input logic [31:0] exp_rd);
        check_value("rd_valid", rd_valid, 64'd1);
        check_value("rd_ill", rd_ill, exp_ill);
        if (!exp_ill) begin
            check_value("rd_data", rd_data, exp_rd);
        end
    endtask

    task automatic drive_random();
        inst_valid = $urandom % 2;
        mtime      = {$urandom, $urandom};
    endtask

    // counter values as seen by the csr read port.
    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            pmu_pkg::csr_cycle_addr, pmu_pkg::csr_mcycle_addr:        return m_cycle[31:0];
            pmu_pkg::csr_cycle_h_addr, pmu_pkg::csr_mcycleh_addr:     return m_cycle[63:32];
            pmu_pkg::csr_instret_addr, pmu_pkg::csr_minstret_addr:    return m_instret[31:0];
            pmu_pkg::csr_instret_h_addr, pmu_pkg::csr_minstreth_addr: return m_instret[63:32];
            pmu_pkg::csr_time_addr:   return mtime[31:0];
            pmu_pkg::csr_time_h_addr: return mtime[63:32];
            default:                  return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] apply_op(input logic [1:0] op, input logic [31:0] old,
                                             input logic [31:0] src);
        case (op)
            2'd1:    return src;
            2'd2:    return old | src;
            2'd3:    return old & ~src;
            default: return old;
        endcase
    endfunction

    function automatic logic op_writes(input logic [1:0] op, input logic [31:0] src);
        return op == 2'd1 || (op != 2'd0 && src != 32'd0); // zero mask is a read.
    endfunction

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        logic [31:0] v_prv;
        logic [31:0] v_id;
        logic [31:0] v_op;
        logic [31:0] v_addr;
        logic [31:0] v_src;
        logic [31:0] v_ill;
        logic [31:0] v_rd;
        fd = $fopen("testbench/pmu_trace.txt", "r");
        if (fd == 0) begin
            stop_on_error("could not open the trace file testbench/pmu_trace.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#" &&
                $sscanf(line, "%h %h %h %h %h %h %h",
                        v_prv, v_id, v_op, v_addr, v_src, v_ill, v_rd) == 7) begin
                t_prv.push_back(v_prv);
                t_id.push_back(v_id);
                t_op.push_back(v_op);
                t_addr.push_back(v_addr);
                t_src.push_back(v_src);
                t_ill.push_back(v_ill);
                t_rd.push_back(v_rd);
            end
        end
        $fclose(fd);
    endtask

    always @(posedge clk_free or negedge rstn) begin
        if (!rstn) begin
            m_cycle   <= 64'd0;
            m_instret <= 64'd0;
        end else begin
            if (pend_wr && pend_addr == pmu_pkg::csr_mcycle_addr) begin
                m_cycle[31:0] <= pend_wdata;
            end else if (pend_wr && pend_addr == pmu_pkg::csr_mcycleh_addr) begin
                m_cycle[63:32] <= pend_wdata;
            end else begin
                m_cycle <= m_cycle + 64'd1;
            end
            if (pend_wr && pend_addr == pmu_pkg::csr_minstret_addr) begin
                m_instret[31:0] <= pend_wdata;
            end else if (pend_wr && pend_addr == pmu_pkg::csr_minstreth_addr) begin
                m_instret[63:32] <= pend_wdata;
            end else begin
                m_instret <= m_instret + inst_valid;
            end
        end
    end

    always @(negedge clk_free) begin
        check_value("mcycle", mcycle, m_cycle);
        assert (pmu_top_inst.pmu_asserts_inst.fail_count == 0)
        else stop_on_error("a concurrent assertion on pmu_top failed");
    end

    always @(posedge clk_free) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            stop_on_error("timeout: the run went past its cycle limit");
        end
    end

    initial begin
        int          seed;
        logic        exp_ill;
        logic [31:0] exp_rd;
        logic        have_prev;
        seed       = $urandom(32'ha0d1);
        rstn       = 1'b0;
        cpu_id     = '0;
        inst_valid = 1'b0;
        prv        = pmu_pkg::prv_m;
        mtime      = 64'd0;
        csr_valid  = 1'b0;
        csr_op     = pmu_pkg::csr_none;
        csr_addr   = 12'd0;
        csr_src    = '0;
        pend_wr    = 1'b0;
        pend_addr  = 12'd0;
        pend_wdata = 32'd0;
        exp_ill    = 1'b0;
        exp_rd     = 32'd0;
        have_prev  = 1'b0;
        load_trace();
        cycle_limit = reset_cycles + t_addr.size() + 50;
        repeat (reset_cycles) begin
            @(negedge clk_free);
            check_value("rd_valid", rd_valid, 64'd0);
            drive_random();
        end
        rstn = 1'b1;
        repeat (2) begin
            @(negedge clk_free);
            check_value("rd_valid", rd_valid, 64'd0);
            check_value("rd_ill", rd_ill, 64'd0);
            drive_random();
        end
        foreach (t_addr[i]) begin
            @(negedge clk_free);
            if (have_prev) check_result(exp_ill, exp_rd);
            drive_random();
            prv       = pmu_pkg::prv_e'(t_prv[i][1:0]);
            cpu_id    = t_id[i];
            csr_valid = 1'b1;
            csr_op    = pmu_pkg::csr_op_e'(t_op[i][1:0]);
            csr_addr  = t_addr[i][11:0];
            csr_src   = t_src[i];
            exp_ill   = t_ill[i][0];
            exp_rd    = (t_rd[i] == 32'hffffffff) ? model_read(csr_addr) : t_rd[i];
            pend_addr  = csr_addr;
            pend_wr    = !exp_ill && op_writes(t_op[i][1:0], csr_src);
            pend_wdata = apply_op(t_op[i][1:0], exp_rd, csr_src);
            have_prev  = 1'b1;
        end
        @(negedge clk_free);
        if (have_prev) check_result(exp_ill, exp_rd);
        csr_valid = 1'b0;
        csr_op    = pmu_pkg::csr_none;
        pend_wr   = 1'b0;
        @(negedge clk_free);
        check_value("rd_valid", rd_valid, 64'd0);
        if (pmu_top_inst.pmu_asserts_inst.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            stop_on_error("a concurrent assertion on pmu_top failed");
        end
    end

endmodule

// File: testbench/pmu_trace.txt
# columns in hex: prv cpu_id op addr src ill rdata, op 1 is rw, 2 is rs, 3 is rc
# rdata ffffffff takes the value from the testbench model, rdata is not checked when ill is 1
3 00000005 2 306 00000000 0 00000000
3 00000005 2 106 00000000 0 00000000
3 00000005 2 7c0 00000000 0 00000000
3 00000005 1 306 0000000a 0 00000000
3 00000005 2 306 00000001 0 0000000a
3 00000005 3 306 00000002 0 0000000b
3 00000005 2 306 00000000 0 00000009
3 00000005 1 106 00000005 0 00000000
3 00000005 2 106 00000000 0 00000005
3 00000005 2 b00 00000000 0 ffffffff
3 00000005 1 b00 00001000 0 ffffffff
3 00000005 2 c00 00000000 0 ffffffff
3 00000005 2 c82 00000000 0 ffffffff
3 00000005 2 c01 00000000 0 ffffffff
3 00000005 2 c81 00000000 0 ffffffff
1 00000005 2 c00 00000000 0 ffffffff
1 00000005 2 c01 00000000 1 00000000
1 00000005 2 c03 00000000 0 00000000
0 00000005 2 c00 00000000 0 ffffffff
0 00000005 2 c02 00000000 1 00000000
0 00000005 2 c03 00000000 1 00000000
0 00000005 1 306 00000000 1 00000000
3 00000005 2 306 00000000 0 00000009
3 00000005 1 c00 00000000 1 00000000
3 00000005 1 f14 00000000 1 00000000
3 0000002a 2 f14 00000000 0 00000005
3 0000002a 2 f14 00000000 0 0000002a
3 00000005 1 b80 00000001 0 ffffffff
3 00000005 2 b80 00000000 0 ffffffff
3 00000005 1 b02 00000100 0 ffffffff
3 00000005 2 c02 00000000 0 ffffffff
